//--- Bender.yml
package:
  name: vseq

sources:
  - files:
      - design/vseq_pkg.sv
      - design/vseq_addr_counter.sv
      - design/vseq_lane_valid.sv
      - design/vseq_bwen_gen.sv
      - design/vseq_ctrl.sv
      - design/vseq_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_vseq.sv

//--- design/vseq_addr_counter.sv
// Element-stepping word address counter for the VRF read and write ports
`timescale 1ns/1ps
`default_nettype none

module vseq_addr_counter import vseq_pkg::*; #(
    parameter  int MEM_DEPTH = 512,
    localparam int ADDR_W    = addr_w(MEM_DEPTH)
) (
    input  logic              clk_i,
    input  logic              rst_i,
    input  logic [ADDR_W-1:0] start_addr_i,
    input  logic              load_i,
    input  logic              step_i,
    input  logic              word_step_i,  // Whole word per step, load beats
    input  elem_width_e       elem_width_i,
    output logic [ADDR_W-1:0] addr_o
);

    logic [ADDR_W-1:0] addr_q;
    logic [1:0]        elem_idx_q;
    logic [1:0]        idx_last;
    logic              word_done;

    assign idx_last  = 2'(elems_per_word(elem_width_i) - 1);
    assign word_done = word_step_i || (elem_idx_q == idx_last);
    assign addr_o    = addr_q;

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            addr_q     <= '0;
            elem_idx_q <= '0;
        end else if (load_i) begin
            addr_q     <= start_addr_i;
            elem_idx_q <= '0;
        end else if (step_i) begin
            if (word_done) begin
                addr_q     <= addr_q + 1'b1; // Last element of the word consumed
                elem_idx_q <= '0;
            end else begin
                elem_idx_q <= elem_idx_q + 1'b1;
            end
        end
    end

    // A vector register must not run off the end of the lane memory
    a_no_addr_wrap: assert property (
        @(posedge clk_i) disable iff (!rst_i)
        (step_i && !load_i && word_done) |-> (addr_q != ADDR_W'(MEM_DEPTH - 1))
    );

endmodule

`default_nettype wire

//--- design/vseq_bwen_gen.sv
// Per-lane byte write enable generator for arithmetic results and load beats
`timescale 1ns/1ps
`default_nettype none

module vseq_bwen_gen import vseq_pkg::*; #(
    parameter int VLANE_NUM = 8
) (
    input  logic                                          clk_i,
    input  logic                                          rst_i,
    input  logic                                          wr_en_i,
    input  logic                                          wr_step_i,
    input  logic                                          load_mode_i,
    input  elem_width_e                                   elem_width_i,
    input  logic [VLANE_NUM-1:0]                          lane_valid_i,
    input  logic [VLANE_NUM-1:0][BYTES_PER_WORD-1:0]      load_bwen_i,
    input  logic                                          load_valid_i,
    output logic [VLANE_NUM-1:0][BYTES_PER_WORD-1:0]      bwen_o
);

    logic [BYTES_PER_WORD-1:0] byte_pat_q;  // One-hot byte select
    logic [1:0]                half_pat_q;  // Lower or upper halfword
    logic [BYTES_PER_WORD-1:0] pattern;

    //////////////////////////////////////////////////////////////////////
    // Rotating patterns, restarted whenever no write is in progress

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            byte_pat_q <= BYTES_PER_WORD'(1);
            half_pat_q <= 2'b01;
        end else if (!wr_en_i) begin
            byte_pat_q <= BYTES_PER_WORD'(1);
            half_pat_q <= 2'b01;
        end else if (wr_step_i) begin
            byte_pat_q <= {byte_pat_q[BYTES_PER_WORD-2:0], byte_pat_q[BYTES_PER_WORD-1]};
            half_pat_q <= {half_pat_q[0], half_pat_q[1]};
        end
    end

    always_comb begin
        case (elem_width_i)
            EW_BYTE: pattern = byte_pat_q;
            EW_HALF: pattern = {{2{half_pat_q[1]}}, {2{half_pat_q[0]}}};
            default: pattern = '1;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Lane outputs

    for (genvar i = 0; i < VLANE_NUM; i++) begin : g_lane
        assign bwen_o[i] = load_mode_i ?
                           (load_bwen_i[i] & {BYTES_PER_WORD{load_valid_i}}) :
                           (pattern & {BYTES_PER_WORD{wr_en_i & lane_valid_i[i]}});
    end

    a_byte_onehot: assert property (
        @(posedge clk_i) disable iff (!rst_i)
        wr_en_i |-> $onehot(byte_pat_q)
    );

endmodule

`default_nettype wire

//--- design/vseq_ctrl.sv
// Sequencer controller: instruction register, step counter and mode FSM
`timescale 1ns/1ps
`default_nettype none

module vseq_ctrl import vseq_pkg::*; #(
    parameter  int VLANE_NUM       = 8,
    parameter  int MAX_VL_PER_LANE = 256,
    localparam int VL_W            = vl_w(VLANE_NUM, MAX_VL_PER_LANE),
    localparam int STEP_W          = step_w(MAX_VL_PER_LANE)
) (
    input  logic              clk_i,
    input  logic              rst_i,
    input  logic              start_i,
    input  inst_kind_e        inst_kind_i,
    input  elem_width_e       vsew_i,
    input  logic [VL_W-1:0]   vl_i,
    input  logic [STEP_W-1:0] inst_delay_i,
    input  logic              load_valid_i,
    input  logic              load_last_i,
    output logic              ready_o,
    output logic              ready_for_load_o,
    output logic              vrf_ren_o,
    output logic              store_data_valid_o,
    output logic              raddr_load_o,
    output logic              raddr_step_o,
    output logic              waddr_load_o,
    output logic              waddr_step_o,
    output logic              word_step_o,
    output logic              valid_load_o,
    output logic              valid_shift_o,
    output logic              wr_en_o,
    output logic              wr_step_o,
    output logic              load_mode_o,
    output elem_width_e       elem_width_o,
    output logic [VL_W-1:0]   vl_o          // Latched length, live while idle
);

    localparam int CNT_W = STEP_W + 1; // Counts up to inst_delay plus R

    seq_state_e        state_q;
    seq_state_e        state_d;
    logic [CNT_W-1:0]  cnt_q;
    logic [CNT_W-1:0]  wr_end;
    logic [STEP_W-1:0] r_d;
    logic [STEP_W-1:0] r_q;
    logic [STEP_W-1:0] delay_q;
    logic [VL_W-1:0]   vl_q;
    elem_width_e       vsew_q;
    logic              ready_q;
    logic              accept;
    logic              rd_step;
    logic              wr_step;
    logic              load_beat;

    assign accept    = start_i && ready_q;
    assign r_d       = STEP_W'(per_lane_elems(vl_i, VLANE_NUM));
    assign wr_end    = CNT_W'(delay_q) + CNT_W'(r_q);

    //////////////////////////////////////////////////////////////////////
    // Mode FSM

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (accept) begin
                    case (inst_kind_i)
                        ARITH:   state_d = ARITH_RUN;
                        STORE:   state_d = STORE_RUN;
                        default: state_d = LOAD_RUN;
                    endcase
                end
            end
            ARITH_RUN: if (cnt_q >= wr_end) state_d = IDLE;  // Last write step done
            STORE_RUN: if (cnt_q + 1'b1 >= CNT_W'(r_q)) state_d = IDLE;
            default:   if (load_valid_i && load_last_i) state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            state_q <= IDLE;
            cnt_q   <= '0;
            ready_q <= 1'b1;
        end else begin
            state_q <= state_d;
            if (state_q == ARITH_RUN || state_q == STORE_RUN) begin
                cnt_q <= cnt_q + 1'b1;
            end else begin
                cnt_q <= '0;
            end
            if (accept) begin
                ready_q <= 1'b0;
            end else if (state_d == IDLE) begin
                ready_q <= 1'b1;
            end
        end
    end

    // Instruction register
    always_ff @(posedge clk_i) begin
        if (accept) begin
            vsew_q  <= vsew_i;
            vl_q    <= vl_i;
            delay_q <= inst_delay_i;
            r_q     <= r_d;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Step and load pulses

    assign rd_step   = (state_q == ARITH_RUN || state_q == STORE_RUN) && (cnt_q < CNT_W'(r_q));
    assign wr_step   = (state_q == ARITH_RUN) && (cnt_q >= CNT_W'(delay_q)) && (cnt_q < wr_end);
    assign load_beat = (state_q == LOAD_RUN) && load_valid_i;

    assign ready_o            = ready_q;
    assign ready_for_load_o   = (state_q == LOAD_RUN);
    assign load_mode_o        = (state_q == LOAD_RUN);
    assign vrf_ren_o          = rd_step;
    assign store_data_valid_o = rd_step && (state_q == STORE_RUN);
    assign raddr_load_o       = accept;
    assign raddr_step_o       = rd_step;
    assign waddr_load_o       = accept;
    assign waddr_step_o       = wr_step || load_beat;
    assign word_step_o        = (state_q == LOAD_RUN); // One word per load beat
    assign wr_en_o            = wr_step;
    assign wr_step_o          = wr_step;
    // Mask restarts so that write step j sees read step j's lanes
    assign valid_load_o       = accept ||
                                ((state_q == ARITH_RUN) && (cnt_q + 1'b1 == CNT_W'(delay_q)));
    assign valid_shift_o      = rd_step || wr_step;
    assign elem_width_o       = vsew_q;
    assign vl_o               = (state_q == IDLE) ? vl_i : vl_q;

    a_ready_only_idle: assert property (
        @(posedge clk_i) disable iff (!rst_i)
        ready_o |-> (state_q == IDLE)
    );

    a_last_with_valid: assert property (
        @(posedge clk_i) disable iff (!rst_i)
        load_last_i |-> load_valid_i
    );

    // One lane mask serves reads and writes, so writes start after the reads
    a_delay_covers_reads: assert property (
        @(posedge clk_i) disable iff (!rst_i)
        (accept && inst_kind_i == ARITH) |-> (inst_delay_i >= r_d)
    );

endmodule

`default_nettype wire

//--- design/vseq_lane_valid.sv
// Per-lane element-valid register, counts down the remaining vector length
`timescale 1ns/1ps
`default_nettype none

module vseq_lane_valid import vseq_pkg::*; #(
    parameter  int VLANE_NUM       = 8,
    parameter  int MAX_VL_PER_LANE = 256,
    localparam int VL_W            = vl_w(VLANE_NUM, MAX_VL_PER_LANE)
) (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic [VL_W-1:0]      vl_i,
    input  logic                 load_i,
    input  logic                 shift_i,
    output logic [VLANE_NUM-1:0] lane_valid_o
);

    logic [VL_W-1:0] remain_q; // Elements not yet stepped over

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            remain_q <= '0;
        end else if (load_i) begin
            remain_q <= vl_i;
        end else if (shift_i) begin
            // One element per lane per step, saturating at zero
            if (remain_q > VL_W'(VLANE_NUM)) begin
                remain_q <= remain_q - VL_W'(VLANE_NUM);
            end else begin
                remain_q <= '0;
            end
        end
    end

    for (genvar i = 0; i < VLANE_NUM; i++) begin : g_lane
        assign lane_valid_o[i] = (remain_q > VL_W'(i));
    end

endmodule

`default_nettype wire

//--- design/vseq_pkg.sv
// Sequencer package: instruction kinds, element widths, states, byte lanes and width helpers
`default_nettype none

package vseq_pkg;

    typedef enum logic [1:0] {
        ARITH = 2'd0,
        STORE = 2'd1,
        LOAD  = 2'd2
    } inst_kind_e;

    typedef enum logic [1:0] {
        EW_BYTE = 2'd0,
        EW_HALF = 2'd1,
        EW_WORD = 2'd2
    } elem_width_e;

    typedef enum logic [1:0] {
        IDLE,
        ARITH_RUN,
        STORE_RUN,
        LOAD_RUN
    } seq_state_e;

    localparam int BYTES_PER_WORD = 4; // Byte lanes in one VRF word

    //////////////////////////////////////////////////////////////////////
    // Width helpers

    function automatic int addr_w(input int mem_depth);
        return $clog2(mem_depth);
    endfunction

    function automatic int vl_w(input int lanes, input int max_vl_per_lane);
        return $clog2(lanes * max_vl_per_lane);
    endfunction

    function automatic int step_w(input int max_vl_per_lane);
        return $clog2(max_vl_per_lane) + 1; // Room for the full per-lane count
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Lane and element helpers

    function automatic int unsigned elems_per_word(input elem_width_e ew);
        case (ew)
            EW_BYTE: return 4;
            EW_HALF: return 2;
            default: return 1;
        endcase
    endfunction

    // Elements each lane holds, rounded up
    function automatic int unsigned per_lane_elems(input int unsigned vl,
                                                   input int unsigned lanes);
        return (vl + lanes - 1) / lanes;
    endfunction

endpackage

`default_nettype wire

//--- design/vseq_top.sv
// Vector sequencer top level: controller, address counters, lane valid and byte enables
`timescale 1ns/1ps
`default_nettype none

module vseq_top import vseq_pkg::*; #(
    parameter  int VLANE_NUM       = 8,
    parameter  int MEM_DEPTH       = 512,
    parameter  int MAX_VL_PER_LANE = 256,
    localparam int ADDR_W          = addr_w(MEM_DEPTH),
    localparam int VL_W            = vl_w(VLANE_NUM, MAX_VL_PER_LANE),
    localparam int STEP_W          = step_w(MAX_VL_PER_LANE)
) (
    input  logic                                     clk_i,
    input  logic                                     rst_i,
    input  logic                                     start_i,
    input  inst_kind_e                               inst_kind_i,
    input  elem_width_e                              vsew_i,
    input  logic [VL_W-1:0]                          vl_i,
    input  logic [STEP_W-1:0]                        inst_delay_i,
    input  logic [ADDR_W-1:0]                        waddr_start_i,
    input  logic [1:0][ADDR_W-1:0]                   raddr_start_i,
    input  logic                                     load_valid_i,
    input  logic                                     load_last_i,
    input  logic [VLANE_NUM-1:0][BYTES_PER_WORD-1:0] load_bwen_i,
    output logic                                     ready_o,
    output logic                                     ready_for_load_o,
    output logic                                     vrf_ren_o,
    output logic [1:0][ADDR_W-1:0]                   vrf_raddr_o,
    output logic [ADDR_W-1:0]                        vrf_waddr_o,
    output logic [VLANE_NUM-1:0][BYTES_PER_WORD-1:0] vrf_bwen_o,
    output logic [VLANE_NUM-1:0]                     read_data_valid_o,
    output logic                                     store_data_valid_o
);

    logic            raddr_load;
    logic            raddr_step;
    logic            waddr_load;
    logic            waddr_step;
    logic            word_step;
    logic            valid_load;
    logic            valid_shift;
    logic            wr_en;
    logic            wr_step;
    logic            load_mode;
    elem_width_e     elem_width;
    logic [VL_W-1:0] vl_latched;

    vseq_ctrl #(
        .VLANE_NUM(VLANE_NUM), .MAX_VL_PER_LANE(MAX_VL_PER_LANE)
    ) u_ctrl (
        .clk_i(clk_i), .rst_i(rst_i),
        .start_i(start_i), .inst_kind_i(inst_kind_i), .vsew_i(vsew_i),
        .vl_i(vl_i), .inst_delay_i(inst_delay_i),
        .load_valid_i(load_valid_i), .load_last_i(load_last_i),
        .ready_o(ready_o), .ready_for_load_o(ready_for_load_o),
        .vrf_ren_o(vrf_ren_o), .store_data_valid_o(store_data_valid_o),
        .raddr_load_o(raddr_load), .raddr_step_o(raddr_step),
        .waddr_load_o(waddr_load), .waddr_step_o(waddr_step), .word_step_o(word_step),
        .valid_load_o(valid_load), .valid_shift_o(valid_shift),
        .wr_en_o(wr_en), .wr_step_o(wr_step), .load_mode_o(load_mode),
        .elem_width_o(elem_width), .vl_o(vl_latched)
    );

    //////////////////////////////////////////////////////////////////////
    // Address counters, two read ports and the write port

    vseq_addr_counter #(.MEM_DEPTH(MEM_DEPTH)) u_raddr0 (
        .clk_i(clk_i), .rst_i(rst_i),
        .start_addr_i(raddr_start_i[0]), .load_i(raddr_load), .step_i(raddr_step),
        .word_step_i(1'b0), .elem_width_i(elem_width), .addr_o(vrf_raddr_o[0])
    );

    vseq_addr_counter #(.MEM_DEPTH(MEM_DEPTH)) u_raddr1 (
        .clk_i(clk_i), .rst_i(rst_i),
        .start_addr_i(raddr_start_i[1]), .load_i(raddr_load), .step_i(raddr_step),
        .word_step_i(1'b0), .elem_width_i(elem_width), .addr_o(vrf_raddr_o[1])
    );

    vseq_addr_counter #(.MEM_DEPTH(MEM_DEPTH)) u_waddr (
        .clk_i(clk_i), .rst_i(rst_i),
        .start_addr_i(waddr_start_i), .load_i(waddr_load), .step_i(waddr_step),
        .word_step_i(word_step), .elem_width_i(elem_width), .addr_o(vrf_waddr_o)
    );

    //////////////////////////////////////////////////////////////////////
    // Lane validity and byte enables

    vseq_lane_valid #(
        .VLANE_NUM(VLANE_NUM), .MAX_VL_PER_LANE(MAX_VL_PER_LANE)
    ) u_valid (
        .clk_i(clk_i), .rst_i(rst_i),
        .vl_i(vl_latched), .load_i(valid_load), .shift_i(valid_shift),
        .lane_valid_o(read_data_valid_o)
    );

    vseq_bwen_gen #(.VLANE_NUM(VLANE_NUM)) u_bwen (
        .clk_i(clk_i), .rst_i(rst_i),
        .wr_en_i(wr_en), .wr_step_i(wr_step), .load_mode_i(load_mode),
        .elem_width_i(elem_width), .lane_valid_i(read_data_valid_o),
        .load_bwen_i(load_bwen_i), .load_valid_i(load_valid_i),
        .bwen_o(vrf_bwen_o)
    );

endmodule

`default_nettype wire

//--- files.f
+incdir+test
design/vseq_pkg.sv
design/vseq_addr_counter.sv
design/vseq_lane_valid.sv
design/vseq_bwen_gen.sv
design/vseq_ctrl.sv
design/vseq_top.sv
test/tb_vseq.sv

//--- test/tb_vseq_tasks.svh
// Directed sequencer tests, the value check, the random source and the instruction driver
`ifndef TB_VSEQ_TASKS_SVH
`define TB_VSEQ_TASKS_SVH

    task automatic check_value(input string test, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        n_checks++;
        if (actual !== expected) begin
            n_errors++;
            $display("FAILED %s %s: expected 0x%0h, actual 0x%0h", test, what, expected, actual);
        end
    endtask

    task automatic report_timeout(input string test);
        n_timeouts++;
        aborted = 1'b1;
        $display("%s: the DUT did not return ready within %0d cycles", test, RUN_TIMEOUT);
    endtask

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int pick_range(input int lo, input int hi);
        logic [31:0] r;
        r = next_random();
        return lo + int'(r[31:8] % (hi - lo + 1)); // Upper bits, better spread
    endfunction

    // Start in the next cycle, return in the first run cycle
    task automatic issue(input inst_kind_e kind, input elem_width_e ew, input int vl,
                         input int delay);
        @(posedge clk_i);
        #DRIVE_DLY;
        start_i          = 1'b1;
        inst_kind_i      = kind;
        vsew_i           = ew;
        vl_i             = VL_W'(vl);
        inst_delay_i     = STEP_W'(delay);
        waddr_start_i    = ADDR_W'(pick_range(0, 400));
        raddr_start_i[0] = ADDR_W'(pick_range(0, 400));
        raddr_start_i[1] = ADDR_W'(pick_range(0, 400));
        @(posedge clk_i); // Accepted here
        #DRIVE_DLY;
        start_i = 1'b0;
    endtask

    task automatic check_read_step(input string test, input int epw, input int vl, input int k);
        check_value(test, "raddr0", raddr_start_i[0] + k / epw, vrf_raddr_o[0]);
        check_value(test, "raddr1", raddr_start_i[1] + k / epw, vrf_raddr_o[1]);
        check_value(test, "read valid", lanes_live(vl, k), read_data_valid_o);
    endtask

    task automatic check_after_reset();
        @(negedge clk_i);
        check_value("reset", "ready", 1, ready_o);
        check_value("reset", "ready_for_load", 0, ready_for_load_o);
        check_value("reset", "ren", 0, vrf_ren_o);
        check_value("reset", "store valid", 0, store_data_valid_o);
        check_value("reset", "read valid", 0, read_data_valid_o);
        check_value("reset", "bwen", 0, vrf_bwen_o);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Arithmetic, optionally with start held through the busy window

    task automatic exercise_arith(input string test, input elem_width_e ew, input bit hold);
        int          vl;
        int          r;
        int          delay;
        int          epw;
        int          c;
        int          rd_count;
        logic [31:0] exp_bwen;
        logic        done;
        if (aborted) return;
        // Sub-word widths get a partial last step
        vl       = (ew == EW_WORD) ? pick_range(1, 64) : 8 * pick_range(1, 7) + pick_range(1, 7);
        r        = (vl + LANES - 1) / LANES;
        delay    = r + pick_range(0, 3);
        epw      = word_elems(ew);
        c        = 0;
        rd_count = 0;
        done     = 1'b0;
        issue(ARITH, ew, vl, delay);
        if (hold) begin
            inst_kind_i = STORE;          // A second instruction that must not start
            vl_i        = VL_W'(vl + 8);
        end
        while (!done) begin
            start_i = hold && (c <= delay + r);
            @(negedge clk_i);
            if (ready_o) begin
                done = 1'b1;
            end else begin
                rd_count += vrf_ren_o;
                check_value(test, "ren", c < r, vrf_ren_o);
                check_value(test, "store valid", 0, store_data_valid_o);
                if (c < r) check_read_step(test, epw, vl, c);
                exp_bwen = '0;
                if (c >= delay && c < delay + r) begin
                    exp_bwen = spread_bwen(lanes_live(vl, c - delay), step_pattern(ew, c - delay));
                    check_value(test, "waddr", waddr_start_i + (c - delay) / epw, vrf_waddr_o);
                end
                check_value(test, "bwen", exp_bwen, vrf_bwen_o);
                c++;
                if (c > RUN_TIMEOUT) begin
                    report_timeout(test);
                    done = 1'b1;
                end else begin
                    @(posedge clk_i);
                    #DRIVE_DLY;
                end
            end
        end
        if (aborted) return;
        check_value(test, "ready cycle", delay + r + 1, c);
        check_value(test, "read steps", r, rd_count);
        if (hold) begin
            repeat (3) begin
                @(negedge clk_i);
                check_value(test, "ren after end", 0, vrf_ren_o);
                check_value(test, "ready after end", 1, ready_o);
            end
        end
    endtask

    task automatic exercise_store(input string test);
        int          vl;
        int          r;
        int          c;
        elem_width_e ew;
        logic        done;
        if (aborted) return;
        ew   = elem_width_e'(2'(pick_range(0, 2)));
        vl   = pick_range(1, 80);
        r    = (vl + LANES - 1) / LANES;
        c    = 0;
        done = 1'b0;
        issue(STORE, ew, vl, 0);
        while (!done) begin
            @(negedge clk_i);
            if (ready_o) begin
                done = 1'b1;
            end else begin
                check_value(test, "ren", c < r, vrf_ren_o);
                check_value(test, "store valid", c < r, store_data_valid_o);
                check_value(test, "bwen", 0, vrf_bwen_o);
                if (c < r) check_read_step(test, word_elems(ew), vl, c);
                c++;
                if (c > RUN_TIMEOUT) begin
                    report_timeout(test);
                    done = 1'b1;
                end else begin
                    @(posedge clk_i);
                    #DRIVE_DLY;
                end
            end
        end
        if (aborted) return;
        check_value(test, "ready cycle", r, c);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Unit-stride load with random gaps between beats

    // Sub-word widths, a beat still moves a whole word
    task automatic exercise_load(input string test, input elem_width_e ew);
        int   beats;
        int   n;
        int   c;
        int   last_c;
        logic done;
        if (aborted) return;
        beats  = pick_range(3, 10);
        n      = 0;
        c      = 0;
        last_c = -1;
        done   = 1'b0;
        issue(LOAD, ew, 8, 0);
        while (!done) begin
            load_valid_i = (n < beats) && (pick_range(0, 2) != 0);
            load_last_i  = load_valid_i && (n == beats - 1);
            load_bwen_i  = next_random(); // Must stay gated on idle cycles
            @(negedge clk_i);
            if (ready_o) begin
                done = 1'b1;
                check_value(test, "ready_for_load at end", 0, ready_for_load_o);
            end else begin
                check_value(test, "ready_for_load", 1, ready_for_load_o);
                check_value(test, "bwen", load_valid_i ? load_bwen_i : 32'd0, vrf_bwen_o);
                if (load_valid_i) begin
                    check_value(test, "waddr", waddr_start_i + n, vrf_waddr_o);
                    if (load_last_i) last_c = c;
                    n++;
                end
                c++;
                if (c > RUN_TIMEOUT) begin
                    report_timeout(test);
                    done = 1'b1;
                end else begin
                    @(posedge clk_i);
                    #DRIVE_DLY;
                end
            end
        end
        load_valid_i = 1'b0;
        load_last_i  = 1'b0;
        if (aborted) return;
        check_value(test, "beats", beats, n);
        check_value(test, "ready cycle", last_c + 1, c);
    endtask

`endif

//--- test/tb_vseq.sv
// Testbench top: clock, reset, DUT instance, expected-value helpers and closing report
`timescale 1ns/1ps
`default_nettype none

module tb_vseq import vseq_pkg::*; ();

    localparam int          LANES       = 8;
    localparam int          MEM_DEPTH   = 512;
    localparam int          MAX_VL      = 256;
    localparam int          ADDR_W      = 9;   // log2 of MEM_DEPTH
    localparam int          VL_W        = 11;  // log2 of LANES * MAX_VL
    localparam int          STEP_W      = 9;
    localparam int          CLK_PERIOD  = 40;
    localparam int          DRIVE_DLY   = 2;
    localparam int          RUN_TIMEOUT = 200; // Cycles allowed per wait loop
    localparam logic [31:0] SEED        = 32'd71868;

    logic                         clk_i;
    logic                         rst_i;
    logic                         start_i;
    inst_kind_e                   inst_kind_i;
    elem_width_e                  vsew_i;
    logic [VL_W-1:0]              vl_i;
    logic [STEP_W-1:0]            inst_delay_i;
    logic [ADDR_W-1:0]            waddr_start_i;
    logic [1:0][ADDR_W-1:0]       raddr_start_i;
    logic                         load_valid_i;
    logic                         load_last_i;
    logic [LANES-1:0][3:0]        load_bwen_i;
    logic                         ready_o;
    logic                         ready_for_load_o;
    logic                         vrf_ren_o;
    logic [1:0][ADDR_W-1:0]       vrf_raddr_o;
    logic [ADDR_W-1:0]            vrf_waddr_o;
    logic [LANES-1:0][3:0]        vrf_bwen_o;
    logic [LANES-1:0]             read_data_valid_o;
    logic                         store_data_valid_o;

    int          n_checks;
    int          n_errors;
    int          n_timeouts;
    logic        aborted;    // Set once a wait loop gives up
    logic [31:0] lcg_state;

    vseq_top #(
        .VLANE_NUM(LANES), .MEM_DEPTH(MEM_DEPTH), .MAX_VL_PER_LANE(MAX_VL)
    ) u_dut (
        .clk_i(clk_i), .rst_i(rst_i),
        .start_i(start_i), .inst_kind_i(inst_kind_i), .vsew_i(vsew_i),
        .vl_i(vl_i), .inst_delay_i(inst_delay_i),
        .waddr_start_i(waddr_start_i), .raddr_start_i(raddr_start_i),
        .load_valid_i(load_valid_i), .load_last_i(load_last_i), .load_bwen_i(load_bwen_i),
        .ready_o(ready_o), .ready_for_load_o(ready_for_load_o),
        .vrf_ren_o(vrf_ren_o), .vrf_raddr_o(vrf_raddr_o), .vrf_waddr_o(vrf_waddr_o),
        .vrf_bwen_o(vrf_bwen_o), .read_data_valid_o(read_data_valid_o),
        .store_data_valid_o(store_data_valid_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    //////////////////////////////////////////////////////////////////////
    // Expected values

    function automatic int word_elems(input elem_width_e ew);
        case (ew)
            EW_BYTE: return 4;
            EW_HALF: return 2;
            default: return 1;
        endcase
    endfunction

    // Lane i is live in step k while k * LANES + i is below vl
    function automatic logic [LANES-1:0] lanes_live(input int vl, input int step);
        logic [LANES-1:0] m;
        for (int i = 0; i < LANES; i++) begin
            m[i] = (step * LANES + i < vl);
        end
        return m;
    endfunction

    function automatic logic [3:0] step_pattern(input elem_width_e ew, input int j);
        case (ew)
            EW_BYTE: return 4'b0001 << (j % 4);
            EW_HALF: return (j % 2 == 0) ? 4'b0011 : 4'b1100;
            default: return 4'b1111;
        endcase
    endfunction

    function automatic logic [31:0] spread_bwen(input logic [LANES-1:0] live,
                                                input logic [3:0] pat);
        logic [31:0] b;
        b = '0;
        for (int i = 0; i < LANES; i++) begin
            if (live[i]) b[4*i +: 4] = pat;
        end
        return b;
    endfunction

    `include "tb_vseq_tasks.svh"

    //////////////////////////////////////////////////////////////////////
    // Test sequence

    initial begin
        n_checks      = 0;
        n_errors      = 0;
        n_timeouts    = 0;
        aborted       = 1'b0;
        lcg_state     = SEED;
        rst_i         = 1'b0;
        start_i       = 1'b0;
        inst_kind_i   = ARITH;
        vsew_i        = EW_WORD;
        vl_i          = '0;
        inst_delay_i  = '0;
        waddr_start_i = '0;
        raddr_start_i = '0;
        load_valid_i  = 1'b0;
        load_last_i   = 1'b0;
        load_bwen_i   = '0;
        repeat (4) @(posedge clk_i);
        #DRIVE_DLY;
        rst_i = 1'b1;

        check_after_reset();
        repeat (2) exercise_arith("arith_word", EW_WORD, 1'b0);
        repeat (2) exercise_arith("arith_byte", EW_BYTE, 1'b0);
        repeat (2) exercise_arith("arith_half", EW_HALF, 1'b0);
        repeat (3) exercise_store("store");
        exercise_load("load_byte", EW_BYTE);
        exercise_load("load_half", EW_HALF);
        exercise_arith("busy_start", EW_WORD, 1'b1);

        $display("Checks %0d, errors %0d, timeouts %0d", n_checks, n_errors, n_timeouts);
        if (n_errors == 0 && n_timeouts == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
